//--- sim.f
verilog/soc_pkg.sv
verilog/dbus_interconnect.sv
verilog/dmem.sv
verilog/uart.sv
verilog/clint.sv
verilog/dbus_subsys_top.sv
test/tb_dbus_subsys.sv

//--- Bender.yml
package:
  name: dbus_subsys

sources:
  - verilog/soc_pkg.sv
  - verilog/dbus_interconnect.sv
  - verilog/dmem.sv
  - verilog/uart.sv
  - verilog/clint.sv
  - verilog/dbus_subsys_top.sv
  - target: test
    files:
      - test/tb_dbus_subsys.sv

//--- test/tb_dbus_subsys.sv
`timescale 1ns/1ps

module tb_dbus_subsys
    import soc_pkg::*;
();

localparam int CLK_PERIOD   = 20;
localparam int DMEM_WORDS   = 256;
localparam int CLKS_PER_BIT = 8;
localparam int TIMEOUT      = 200;

logic          clk;
logic          rst_i;
axi_lite_req_t bus_req;
axi_lite_rsp_t bus_rsp;
logic          uart_txd;
logic          uart_irq;
logic          timer_irq;

int            errors;
int            cycle = 0;
logic [1:0]    exp_resp;
logic          check_rdata;
logic [31:0]   exp_rdata;
// Expected data memory contents by word index
logic [31:0]   mem_model [int];

// TX looped straight back into RX
dbus_subsys_top #(
    .DMEM_WORDS        (DMEM_WORDS),
    .UART_CLKS_PER_BIT (CLKS_PER_BIT)
) u_dbus_subsys_top (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .uart_rxd_i  (uart_txd),
    .uart_txd_o  (uart_txd),
    .uart_irq_o  (uart_irq),
    .timer_irq_o (timer_irq)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

always @(posedge clk) begin
    cycle <= cycle + 1;
end

// Idle outputs while in reset and in the first cycle after it
reset_outputs: assert property (@(posedge clk) rst_i |=>
    (!bus_rsp.aw_ready && !bus_rsp.w_ready && !bus_rsp.ar_ready && !bus_rsp.b_valid
     && !bus_rsp.r_valid && uart_txd && !uart_irq && !timer_irq))
else begin
    errors++;
    $display("MISMATCH reset state: ready %h valid %h txd %h irq %h, expected 0 0 1 0",
             $sampled({bus_rsp.aw_ready, bus_rsp.w_ready, bus_rsp.ar_ready}),
             $sampled({bus_rsp.b_valid, bus_rsp.r_valid}), $sampled(uart_txd),
             $sampled({uart_irq, timer_irq}));
end

b_held: assert property (@(posedge clk) disable iff (rst_i)
    (bus_rsp.b_valid && !bus_req.b_ready) |=> (bus_rsp.b_valid && $stable(bus_rsp.b_resp)))
else begin
    errors++;
    $display("Write response dropped or changed before b_ready");
end

r_held: assert property (@(posedge clk) disable iff (rst_i)
    (bus_rsp.r_valid && !bus_req.r_ready) |=>
    (bus_rsp.r_valid && $stable(bus_rsp.r_data) && $stable(bus_rsp.r_resp)))
else begin
    errors++;
    $display("Read response dropped or changed before r_ready");
end

// Only one transaction in flight
no_accept: assert property (@(posedge clk) disable iff (rst_i)
    (bus_rsp.b_valid || bus_rsp.r_valid) |->
    !(bus_rsp.aw_ready || bus_rsp.w_ready || bus_rsp.ar_ready))
else begin
    errors++;
    $display("New address accepted while a response was pending");
end

b_resp_ok: assert property (@(posedge clk) disable iff (rst_i)
    (bus_rsp.b_valid && bus_req.b_ready) |-> (bus_rsp.b_resp == exp_resp))
else begin
    errors++;
    $display("MISMATCH b_resp expected %h actual %h", $sampled(exp_resp),
             $sampled(bus_rsp.b_resp));
end

r_resp_ok: assert property (@(posedge clk) disable iff (rst_i)
    (bus_rsp.r_valid && bus_req.r_ready) |-> (bus_rsp.r_resp == exp_resp))
else begin
    errors++;
    $display("MISMATCH r_resp expected %h actual %h", $sampled(exp_resp),
             $sampled(bus_rsp.r_resp));
end

r_data_ok: assert property (@(posedge clk) disable iff (rst_i)
    (bus_rsp.r_valid && bus_req.r_ready && check_rdata) |-> (bus_rsp.r_data == exp_rdata))
else begin
    errors++;
    $display("MISMATCH r_data expected %h actual %h", $sampled(exp_rdata),
             $sampled(bus_rsp.r_data));
end

function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0]  strb);
    logic [31:0] lane_mask;
    lane_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~lane_mask) | (new_word & lane_mask);
endfunction

// Ready is sampled a quarter period after the falling edge
task automatic start_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic accepted;
    int   n;
    @(negedge clk);
    bus_req.aw_valid = 1'b1;
    bus_req.aw_addr  = addr;
    bus_req.w_valid  = 1'b1;
    bus_req.w_data   = data;
    bus_req.w_strb   = strb;
    accepted = 1'b0;
    n = 0;
    while (!accepted && n < TIMEOUT) begin
        #(CLK_PERIOD / 4);
        accepted = bus_rsp.aw_ready && bus_rsp.w_ready;
        @(negedge clk);
        n++;
    end
    bus_req.aw_valid = 1'b0;
    bus_req.w_valid  = 1'b0;
    if (!accepted) begin
        errors++;
        $display("Write to %h was never accepted", addr);
    end
endtask

task automatic start_read(input logic [31:0] addr);
    logic accepted;
    int   n;
    @(negedge clk);
    bus_req.ar_valid = 1'b1;
    bus_req.ar_addr  = addr;
    accepted = 1'b0;
    n = 0;
    while (!accepted && n < TIMEOUT) begin
        #(CLK_PERIOD / 4);
        accepted = bus_rsp.ar_ready;
        @(negedge clk);
        n++;
    end
    bus_req.ar_valid = 1'b0;
    if (!accepted) begin
        errors++;
        $display("Read from %h was never accepted", addr);
    end
endtask

// Holds b_ready low for hold cycles once b_valid is seen
task automatic collect_b(input int hold, output logic [1:0] resp);
    int n;
    n = 0;
    resp = 2'bxx;
    while (!bus_rsp.b_valid && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (!bus_rsp.b_valid) begin
        errors++;
        $display("Write response never arrived");
    end else begin
        repeat (hold) @(negedge clk);
        resp = bus_rsp.b_resp;
        bus_req.b_ready = 1'b1;
        @(negedge clk);
        bus_req.b_ready = 1'b0;
    end
endtask

task automatic collect_r(input int hold, output logic [31:0] data, output logic [1:0] resp);
    int n;
    n = 0;
    data = 'x;
    resp = 2'bxx;
    while (!bus_rsp.r_valid && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (!bus_rsp.r_valid) begin
        errors++;
        $display("Read response never arrived");
    end else begin
        repeat (hold) @(negedge clk);
        data = bus_rsp.r_data;
        resp = bus_rsp.r_resp;
        bus_req.r_ready = 1'b1;
        @(negedge clk);
        bus_req.r_ready = 1'b0;
    end
endtask

task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input logic [1:0] want_resp,
                         input int hold, output logic [1:0] resp);
    exp_resp = want_resp;
    start_write(addr, data, strb);
    collect_b(hold, resp);
endtask

task automatic axi_read(input logic [31:0] addr, input logic [1:0] want_resp,
                        input logic check, input logic [31:0] want_data,
                        input int hold, output logic [31:0] data, output logic [1:0] resp);
    exp_resp    = want_resp;
    check_rdata = check;
    exp_rdata   = want_data;
    start_read(addr);
    collect_r(hold, data, resp);
    check_rdata = 1'b0;
endtask

initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
    logic [31:0] t1;
    logic [31:0] t2;
    logic [1:0]  resp;
    logic [3:0]  strb;
    logic [7:0]  tx_byte;
    int          idx;
    int          c1;
    int          c2;
    int          n;

    errors      = 0;
    rst_i       = 1'b1;
    bus_req     = '0;
    exp_resp    = RESP_OKAY;
    check_rdata = 1'b0;
    exp_rdata   = '0;
    void'($urandom(32'h5d00bd61));

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    // Data memory test on 16 words spread over the array so partial writes hit old data
    repeat (40) begin
        idx  = $urandom_range(7, 0) * (DMEM_WORDS / 8) + $urandom_range(1, 0);
        addr = DMEM_BASE | 32'(idx << 2);
        data = $urandom;
        if (!mem_model.exists(idx)) begin
            mem_model[idx] = 32'h0;
            strb = 4'hF;
        end else begin
            strb = 4'($urandom);
        end
        axi_write(addr, data, strb, RESP_OKAY, $urandom_range(3, 0), resp);
        mem_model[idx] = merge_bytes(mem_model[idx], data, strb);
        axi_read(addr, RESP_OKAY, 1'b1, mem_model[idx], $urandom_range(3, 0), rdata, resp);
    end

    // Unmapped window
    axi_write(32'h3000_0000, $urandom, 4'hF, RESP_DECERR, $urandom_range(5, 0), resp);
    axi_read(32'h3000_0004, RESP_DECERR, 1'b1, 32'h0, $urandom_range(5, 0), rdata, resp);

    // Read offered while the write response is stalled
    idx  = DMEM_WORDS - 1;
    addr = DMEM_BASE | 32'(idx << 2);
    data = $urandom;
    exp_resp = RESP_OKAY;
    start_write(addr, data, 4'hF);
    fork
        collect_b($urandom_range(10, 3), resp);
        start_read(addr);
    join
    // Write offered while the read response is stalled
    check_rdata = 1'b1;
    exp_rdata   = data;
    fork
        collect_r($urandom_range(10, 3), rdata, resp);
        start_write(addr, ~data, 4'hF);
    join
    check_rdata = 1'b0;
    collect_b($urandom_range(3, 0), resp);
    axi_read(addr, RESP_OKAY, 1'b1, ~data, 0, rdata, resp);

    // UART loopback
    axi_write(UART_BASE | 32'(UART_CTRL), 32'h1, 4'hF, RESP_OKAY, 0, resp);
    tx_byte = 8'($urandom);
    axi_write(UART_BASE | 32'(UART_TXDATA), {24'h0, tx_byte}, 4'hF, RESP_OKAY, 0, resp);
    axi_read(UART_BASE | 32'(UART_TXDATA), RESP_OKAY, 1'b1, 32'h1, 0, rdata, resp);
    // Dropped while busy so the frame in progress must come back intact
    axi_write(UART_BASE | 32'(UART_TXDATA), {24'h0, ~tx_byte}, 4'hF, RESP_OKAY, 0, resp);
    n = 0;
    while (!uart_irq && n < 12 * CLKS_PER_BIT) begin
        @(negedge clk);
        n++;
    end
    if (!uart_irq) begin
        errors++;
        $display("UART receive interrupt did not rise within twelve bit times");
    end
    axi_read(UART_BASE | 32'(UART_RXDATA), RESP_OKAY, 1'b1, {23'h0, 1'b1, tx_byte}, 0,
             rdata, resp);
    assert (uart_irq == 1'b0) else begin
        errors++;
        $display("MISMATCH uart_irq_o expected %h actual %h", 1'b0, uart_irq);
    end
    // No second frame may follow
    repeat (12 * CLKS_PER_BIT) @(negedge clk);
    axi_read(UART_BASE | 32'(UART_RXDATA), RESP_OKAY, 1'b1, {23'h0, 1'b0, tx_byte}, 0,
             rdata, resp);

    // CLINT timer with the same read latency on both samples
    axi_read(CLINT_BASE | 32'(CLINT_MTIME_LO), RESP_OKAY, 1'b0, 32'h0, 0, t1, resp);
    c1 = cycle;
    repeat (50) @(negedge clk);
    axi_read(CLINT_BASE | 32'(CLINT_MTIME_LO), RESP_OKAY, 1'b0, 32'h0, 0, t2, resp);
    c2 = cycle;
    assert (t2 - t1 >= 32'(c2 - c1)) else begin
        errors++;
        $display("MISMATCH mtime delta expected at least %h actual %h", c2 - c1, t2 - t1);
    end

    axi_write(CLINT_BASE | 32'(CLINT_MTIMECMP_LO), t2 + 32'd400, 4'hF, RESP_OKAY, 0, resp);
    axi_write(CLINT_BASE | 32'(CLINT_MTIMECMP_HI), 32'h0, 4'hF, RESP_OKAY, 0, resp);
    n = 0;
    while (!timer_irq && n < 600) begin
        @(negedge clk);
        n++;
    end
    if (!timer_irq) begin
        errors++;
        $display("Timer interrupt did not rise after mtimecmp was reached");
    end
    assert (n >= 300) else begin
        errors++;
        $display("Timer interrupt rose after only %0d cycles", n);
    end
    axi_write(CLINT_BASE | 32'(CLINT_MTIMECMP_HI), 32'hFFFF_FFFF, 4'hF, RESP_OKAY, 0, resp);
    assert (timer_irq == 1'b0) else begin
        errors++;
        $display("MISMATCH timer_irq_o expected %h actual %h", 1'b0, timer_irq);
    end

    repeat (4) @(negedge clk);
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
        $display("ALL CHECKS PASSED");
    end else begin
        $display("CHECKS FAILED");
    end
    $finish;
end

endmodule : tb_dbus_subsys

//--- verilog/dbus_subsys_top.sv
`timescale 1ns/1ps

module dbus_subsys_top
    import soc_pkg::*;
#(
    parameter int DMEM_WORDS        = 1024,
    parameter int UART_CLKS_PER_BIT = 16
) (
    input  logic          clk,
    input  logic          rst_i,

    input  axi_lite_req_t bus_req_i,
    output axi_lite_rsp_t bus_rsp_o,

    input  logic          uart_rxd_i,
    output logic          uart_txd_o,
    output logic          uart_irq_o,
    output logic          timer_irq_o
);

// Shared request, one response per peripheral
peri_req_t dbus2peri;
peri_rsp_t dmem2dbus;
peri_rsp_t uart2dbus;
peri_rsp_t clint2dbus;

logic      dmem_sel;
logic      uart_sel;
logic      clint_sel;

dbus_interconnect dbus_interconnect_module (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req_i),
    .bus_rsp_o   (bus_rsp_o),
    .peri_req_o  (dbus2peri),
    .dmem_sel_o  (dmem_sel),
    .uart_sel_o  (uart_sel),
    .clint_sel_o (clint_sel),
    .dmem_rsp_i  (dmem2dbus),
    .uart_rsp_i  (uart2dbus),
    .clint_rsp_i (clint2dbus)
);

dmem #(
    .DMEM_WORDS (DMEM_WORDS)
) dmem_module (
    .clk        (clk),
    .rst_i      (rst_i),
    .peri_req_i (dbus2peri),
    .dmem_sel_i (dmem_sel),
    .dmem_rsp_o (dmem2dbus)
);

uart #(
    .UART_CLKS_PER_BIT (UART_CLKS_PER_BIT)
) uart_module (
    .clk        (clk),
    .rst_i      (rst_i),
    .peri_req_i (dbus2peri),
    .uart_sel_i (uart_sel),
    .uart_rsp_o (uart2dbus),
    .uart_irq_o (uart_irq_o),
    .uart_rxd_i (uart_rxd_i),
    .uart_txd_o (uart_txd_o)
);

clint clint_module (
    .clk         (clk),
    .rst_i       (rst_i),
    .peri_req_i  (dbus2peri),
    .clint_sel_i (clint_sel),
    .clint_rsp_o (clint2dbus),
    .timer_irq_o (timer_irq_o)
);

endmodule : dbus_subsys_top

//--- verilog/clint.sv
`timescale 1ns/1ps

module clint
    import soc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,

    input  peri_req_t peri_req_i,
    input  logic      clint_sel_i,
    output peri_rsp_t clint_rsp_o,
    output logic      timer_irq_o
);

logic [63:0] mtime;
logic [63:0] mtimecmp;
logic        wr_en;
logic        rd_en;

assign wr_en = clint_sel_i && peri_req_i.wr;
assign rd_en = clint_sel_i && peri_req_i.rd;

// Free-running timer, a write replaces the increment for that cycle
always_ff @(posedge clk) begin
    if (rst_i) begin
        mtime <= '0;
    end else if (wr_en && (peri_req_i.addr == CLINT_MTIME_LO)) begin
        mtime[31:0] <= merge_strb(mtime[31:0], peri_req_i.wdata, peri_req_i.wstrb);
    end else if (wr_en && (peri_req_i.addr == CLINT_MTIME_HI)) begin
        mtime[63:32] <= merge_strb(mtime[63:32], peri_req_i.wdata, peri_req_i.wstrb);
    end else begin
        mtime <= mtime + 64'd1;
    end
end

// All ones keeps the interrupt off after reset
always_ff @(posedge clk) begin
    if (rst_i) begin
        mtimecmp <= '1;
    end else if (wr_en) begin
        case (peri_req_i.addr)
            CLINT_MTIMECMP_LO: begin
                mtimecmp[31:0] <= merge_strb(mtimecmp[31:0], peri_req_i.wdata,
                                             peri_req_i.wstrb);
            end
            CLINT_MTIMECMP_HI: begin
                mtimecmp[63:32] <= merge_strb(mtimecmp[63:32], peri_req_i.wdata,
                                              peri_req_i.wstrb);
            end
            default: mtimecmp <= mtimecmp;
        endcase
    end
end

assign timer_irq_o = (mtime >= mtimecmp);

always_ff @(posedge clk) begin
    if (rst_i) begin
        clint_rsp_o.rdata <= '0;
    end else if (rd_en) begin
        case (peri_req_i.addr)
            CLINT_MTIMECMP_LO: clint_rsp_o.rdata <= mtimecmp[31:0];
            CLINT_MTIMECMP_HI: clint_rsp_o.rdata <= mtimecmp[63:32];
            CLINT_MTIME_LO:    clint_rsp_o.rdata <= mtime[31:0];
            CLINT_MTIME_HI:    clint_rsp_o.rdata <= mtime[63:32];
            default:           clint_rsp_o.rdata <= '0;
        endcase
    end
end

endmodule : clint

//--- verilog/uart.sv
`timescale 1ns/1ps

module uart
    import soc_pkg::*;
#(
    parameter int UART_CLKS_PER_BIT = 16
) (
    input  logic      clk,
    input  logic      rst_i,

    input  peri_req_t peri_req_i,
    input  logic      uart_sel_i,
    output peri_rsp_t uart_rsp_o,
    output logic      uart_irq_o,

    input  logic      uart_rxd_i,
    output logic      uart_txd_o
);

localparam int CNT_W = $clog2(UART_CLKS_PER_BIT + 1);
localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(UART_CLKS_PER_BIT - 1);
localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(UART_CLKS_PER_BIT / 2 - 1);

logic             tx_wr;
logic             rx_rd;
logic             ctrl_wr;
logic             rx_ie;

logic             tx_busy;
logic [9:0]       tx_shift;
logic [3:0]       tx_bit_cnt;
logic [CNT_W-1:0] tx_clk_cnt;

logic [1:0]       rx_sync;
logic             rx_busy;
logic [3:0]       rx_bit_cnt;
logic [CNT_W-1:0] rx_clk_cnt;
logic [7:0]       rx_shift;
logic [7:0]       rx_data;
logic             rx_valid;

assign tx_wr   = uart_sel_i && peri_req_i.wr && (peri_req_i.addr == UART_TXDATA);
assign ctrl_wr = uart_sel_i && peri_req_i.wr && (peri_req_i.addr == UART_CTRL);
assign rx_rd   = uart_sel_i && peri_req_i.rd && (peri_req_i.addr == UART_RXDATA);

// Transmitter, frame is {stop, data, start} shifted out LSB first
always_ff @(posedge clk) begin
    if (rst_i) begin
        tx_busy    <= 1'b0;
        tx_bit_cnt <= '0;
        tx_clk_cnt <= '0;
    end else if (!tx_busy) begin
        // Writes while busy never reach this branch
        if (tx_wr) begin
            tx_busy    <= 1'b1;
            tx_shift   <= {1'b1, peri_req_i.wdata[7:0], 1'b0};
            tx_bit_cnt <= '0;
            tx_clk_cnt <= '0;
        end
    end else if (tx_clk_cnt == BIT_LAST) begin
        tx_clk_cnt <= '0;
        if (tx_bit_cnt == 4'd9) begin
            tx_busy <= 1'b0;
        end else begin
            tx_bit_cnt <= tx_bit_cnt + 4'd1;
            tx_shift   <= {1'b1, tx_shift[9:1]};
        end
    end else begin
        tx_clk_cnt <= tx_clk_cnt + 1'b1;
    end
end

assign uart_txd_o = tx_busy ? tx_shift[0] : 1'b1;

// Receiver, bit 0 is the start bit and bit 9 the stop bit
always_ff @(posedge clk) begin
    if (rst_i) begin
        rx_sync    <= 2'b11;
        rx_busy    <= 1'b0;
        rx_bit_cnt <= '0;
        rx_clk_cnt <= '0;
        rx_valid   <= 1'b0;
    end else begin
        rx_sync <= {rx_sync[0], uart_rxd_i};
        if (rx_rd) begin
            rx_valid <= 1'b0;
        end
        if (!rx_busy) begin
            if (!rx_sync[1]) begin
                rx_busy    <= 1'b1;
                rx_bit_cnt <= '0;
                rx_clk_cnt <= HALF_BIT;
            end
        end else if (rx_clk_cnt != '0) begin
            rx_clk_cnt <= rx_clk_cnt - 1'b1;
        end else begin
            // Mid-bit sample point
            rx_clk_cnt <= BIT_LAST;
            rx_bit_cnt <= rx_bit_cnt + 4'd1;
            if (rx_bit_cnt == 4'd0) begin
                // Glitch, not a real start bit
                if (rx_sync[1]) begin
                    rx_busy <= 1'b0;
                end
            end else if (rx_bit_cnt == 4'd9) begin
                rx_busy <= 1'b0;
                if (rx_sync[1]) begin
                    rx_data  <= rx_shift;
                    rx_valid <= 1'b1;
                end
            end else begin
                rx_shift <= {rx_sync[1], rx_shift[7:1]};
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        rx_ie <= 1'b0;
    end else if (ctrl_wr) begin
        rx_ie <= peri_req_i.wdata[0];
    end
end

assign uart_irq_o = rx_valid && rx_ie;

// Register read port
always_ff @(posedge clk) begin
    if (rst_i) begin
        uart_rsp_o.rdata <= '0;
    end else if (uart_sel_i && peri_req_i.rd) begin
        case (peri_req_i.addr)
            UART_TXDATA: uart_rsp_o.rdata <= {31'b0, tx_busy};
            UART_RXDATA: uart_rsp_o.rdata <= {23'b0, rx_valid, rx_data};
            UART_CTRL:   uart_rsp_o.rdata <= {31'b0, rx_ie};
            default:     uart_rsp_o.rdata <= '0;
        endcase
    end
end

endmodule : uart

//--- verilog/dmem.sv
`timescale 1ns/1ps

module dmem
    import soc_pkg::*;
#(
    // Power of two, at most 16384 words in the 64 KiB window
    parameter int DMEM_WORDS = 1024
) (
    input  logic      clk,
    input  logic      rst_i,

    input  peri_req_t peri_req_i,
    input  logic      dmem_sel_i,
    output peri_rsp_t dmem_rsp_o
);

localparam int IDX_W = $clog2(DMEM_WORDS);

logic [31:0]      mem [DMEM_WORDS];
logic [IDX_W-1:0] idx;
logic             wr_en;
logic             rd_en;

// Upper offset bits are dropped so the address wraps
assign idx   = peri_req_i.addr[IDX_W+1:2];
assign wr_en = dmem_sel_i && peri_req_i.wr;
assign rd_en = dmem_sel_i && peri_req_i.rd;

// Byte lane writes
always_ff @(posedge clk) begin
    if (wr_en) begin
        for (int b = 0; b < 4; b++) begin
            if (peri_req_i.wstrb[b]) begin
                mem[idx][8*b +: 8] <= peri_req_i.wdata[8*b +: 8];
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        dmem_rsp_o.rdata <= '0;
    end else if (rd_en) begin
        dmem_rsp_o.rdata <= mem[idx];
    end
end

endmodule : dmem

//--- verilog/dbus_interconnect.sv
`timescale 1ns/1ps

module dbus_interconnect
    import soc_pkg::*;
(
    input  logic          clk,
    input  logic          rst_i,

    // External AXI4-Lite slave port
    input  axi_lite_req_t bus_req_i,
    output axi_lite_rsp_t bus_rsp_o,

    // Peripheral side
    output peri_req_t     peri_req_o,
    output logic          dmem_sel_o,
    output logic          uart_sel_o,
    output logic          clint_sel_o,
    input  peri_rsp_t     dmem_rsp_i,
    input  peri_rsp_t     uart_rsp_i,
    input  peri_rsp_t     clint_rsp_i
);

typedef enum logic [1:0] {ST_IDLE, ST_STROBE, ST_CAPTURE, ST_RESPOND} state_e;

state_e      state_q;
logic        rd_go;
logic        wr_go;
logic [31:0] dec_addr;
// One-hot {clint, uart, dmem}
logic [2:0]  dec_sel;
logic [2:0]  sel_q;
logic        is_wr_q;
logic [15:0] off_q;
logic [31:0] wdata_q;
logic [3:0]  wstrb_q;
logic [1:0]  resp_q;
logic [31:0] rdata_mux;
logic [31:0] rdata_q;
logic        b_valid_q;
logic        r_valid_q;

// Read has priority over a pending write
assign rd_go = (state_q == ST_IDLE) && bus_req_i.ar_valid;
assign wr_go = (state_q == ST_IDLE) && !bus_req_i.ar_valid
             && bus_req_i.aw_valid && bus_req_i.w_valid;

assign dec_addr = bus_req_i.ar_valid ? bus_req_i.ar_addr : bus_req_i.aw_addr;

always_comb begin
    dec_sel[0] = (dec_addr & DMEM_MASK)  == DMEM_BASE;
    dec_sel[1] = (dec_addr & UART_MASK)  == UART_BASE;
    dec_sel[2] = (dec_addr & CLINT_MASK) == CLINT_BASE;
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        state_q   <= ST_IDLE;
        sel_q     <= '0;
        b_valid_q <= 1'b0;
        r_valid_q <= 1'b0;
    end else begin
        case (state_q)
            ST_IDLE: begin
                if (rd_go || wr_go) begin
                    state_q <= ST_STROBE;
                    sel_q   <= dec_sel;
                end
            end
            ST_STROBE: state_q <= ST_CAPTURE;
            ST_CAPTURE: begin
                state_q   <= ST_RESPOND;
                b_valid_q <= is_wr_q;
            end
            ST_RESPOND: begin
                if (is_wr_q) begin
                    if (bus_req_i.b_ready) begin
                        b_valid_q <= 1'b0;
                        sel_q     <= '0;
                        state_q   <= ST_IDLE;
                    end
                end else if (!r_valid_q) begin
                    // Data was captured on the previous edge
                    r_valid_q <= 1'b1;
                end else if (bus_req_i.r_ready) begin
                    r_valid_q <= 1'b0;
                    sel_q     <= '0;
                    state_q   <= ST_IDLE;
                end
            end
            default: state_q <= ST_IDLE;
        endcase
    end
end

// Transaction payload
always_ff @(posedge clk) begin
    if (rd_go || wr_go) begin
        is_wr_q <= wr_go;
        off_q   <= {dec_addr[15:2], 2'b00};
        wdata_q <= bus_req_i.w_data;
        wstrb_q <= bus_req_i.w_strb;
        resp_q  <= (|dec_sel) ? RESP_OKAY : RESP_DECERR;
    end
    if (state_q == ST_CAPTURE) begin
        rdata_q <= rdata_mux;
    end
end

// Unmapped reads fall through to zero
always_comb begin
    rdata_mux = '0;
    if (sel_q[0]) begin
        rdata_mux = dmem_rsp_i.rdata;
    end else if (sel_q[1]) begin
        rdata_mux = uart_rsp_i.rdata;
    end else if (sel_q[2]) begin
        rdata_mux = clint_rsp_i.rdata;
    end
end

always_comb begin
    peri_req_o.wr    = (state_q == ST_STROBE) && is_wr_q && (|sel_q);
    peri_req_o.rd    = (state_q == ST_STROBE) && !is_wr_q && (|sel_q);
    peri_req_o.addr  = off_q;
    peri_req_o.wdata = wdata_q;
    peri_req_o.wstrb = wstrb_q;
end

assign dmem_sel_o  = sel_q[0];
assign uart_sel_o  = sel_q[1];
assign clint_sel_o = sel_q[2];

always_comb begin
    bus_rsp_o.aw_ready = wr_go;
    bus_rsp_o.w_ready  = wr_go;
    bus_rsp_o.b_valid  = b_valid_q;
    bus_rsp_o.b_resp   = resp_q;
    bus_rsp_o.ar_ready = rd_go;
    bus_rsp_o.r_valid  = r_valid_q;
    bus_rsp_o.r_data   = rdata_q;
    bus_rsp_o.r_resp   = resp_q;
end

endmodule : dbus_interconnect

//--- verilog/soc_pkg.sv
package soc_pkg;

    // AXI4-Lite channels driven by the master
    typedef struct packed {
        logic        aw_valid;
        logic [31:0] aw_addr;
        logic        w_valid;
        logic [31:0] w_data;
        logic [3:0]  w_strb;
        logic        b_ready;
        logic        ar_valid;
        logic [31:0] ar_addr;
        logic        r_ready;
    } axi_lite_req_t;

    // AXI4-Lite channels driven by the slave
    typedef struct packed {
        logic        aw_ready;
        logic        w_ready;
        logic        b_valid;
        logic [1:0]  b_resp;
        logic        ar_ready;
        logic        r_valid;
        logic [31:0] r_data;
        logic [1:0]  r_resp;
    } axi_lite_rsp_t;

    // Broadcast from the interconnect to every peripheral
    // addr is the word-aligned byte offset inside the selected window
    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [15:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } peri_req_t;

    // Read data, due one cycle after rd
    typedef struct packed {
        logic [31:0] rdata;
    } peri_rsp_t;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    // Address map
    localparam logic [31:0] DMEM_BASE  = 32'h0000_0000;
    localparam logic [31:0] DMEM_MASK  = 32'hFFFF_0000;
    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [31:0] CLINT_MASK = 32'hFFFF_0000;
    localparam logic [31:0] UART_BASE  = 32'h1000_0000;
    localparam logic [31:0] UART_MASK  = 32'hFFFF_F000;

    // UART registers
    localparam logic [15:0] UART_TXDATA = 16'h0000;
    localparam logic [15:0] UART_RXDATA = 16'h0004;
    localparam logic [15:0] UART_CTRL   = 16'h0008;

    // CLINT registers
    localparam logic [15:0] CLINT_MTIMECMP_LO = 16'h4000;
    localparam logic [15:0] CLINT_MTIMECMP_HI = 16'h4004;
    localparam logic [15:0] CLINT_MTIME_LO    = 16'hBFF8;
    localparam logic [15:0] CLINT_MTIME_HI    = 16'hBFFC;

    // Replace only the strobed bytes of a word
    function automatic logic [31:0] merge_strb(logic [31:0] old_word,
                                               logic [31:0] new_word,
                                               logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage : soc_pkg
